// ==== build.f ====
+incdir+include
source/rv_pkg.sv
source/rv_ifs.sv
source/if_stage.sv
source/id_stage.sv
source/forwarding.sv
source/ex_stage.sv
source/ls_stage.sv
source/rv_core.sv
dv/rv_core_tb.sv

// ==== dv/rv_core_tb.sv ====
`include "rv_consts.svh"

module rv_core_tb;

    localparam logic [31:0] NOP = 32'h0000_0013;

    logic                   clk = 1'b0;
    logic                   arst_n;
    logic [`INST_LEN-1:0]   imem_data;
    logic [`XLEN-1:0]       imem_addr;
    logic                   retire_valid;
    logic [`XLEN-1:0]       retire_pc;
    logic [4:0]             retire_rd;
    logic [`XLEN-1:0]       retire_data;

    // program words and expected retirements packed as {pc, rd, data}
    logic [31:0]            prog_q [$];
    logic [68:0]            exp_q [$];
    int                     ret_idx;
    int                     cycle_cnt = 0;

    rv_core dut0 (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .imem_data_i    (imem_data),
        .imem_addr_o    (imem_addr),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc),
        .retire_rd_o    (retire_rd),
        .retire_data_o  (retire_data)
    );

    always #4 clk = ~clk;

    // instruction encoders following the ISA field layout
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        int idx;
        idx = int'(addr[31:2]);
        if (idx < prog_q.size()) begin
            return prog_q[idx];
        end
        return NOP;
    endfunction

    task automatic load_program();
        // ALU chain reading results at distances 1 and 2
        prog_q.push_back(enc_i(12'h0f0, 5'd0, 3'b000, 5'd1, `OP_IMM));
        prog_q.push_back(enc_i(12'h00f, 5'd1, 3'b000, 5'd2, `OP_IMM));
        prog_q.push_back(enc_r(7'h00, 5'd1, 5'd2, 3'b000, 5'd3));
        prog_q.push_back(enc_r(7'h20, 5'd2, 5'd3, 3'b000, 5'd4));
        prog_q.push_back(enc_r(7'h00, 5'd3, 5'd4, 3'b111, 5'd5));
        prog_q.push_back(enc_r(7'h00, 5'd4, 5'd5, 3'b110, 5'd6));
        prog_q.push_back(enc_r(7'h00, 5'd5, 5'd6, 3'b100, 5'd7));
        prog_q.push_back({20'h12345, 5'd8, `OP_LUI});
        prog_q.push_back(enc_r(7'h00, 5'd7, 5'd8, 3'b000, 5'd9));
        // store and load back, then use the load at distance 2
        prog_q.push_back(enc_s(12'h008, 5'd9, 5'd0));
        prog_q.push_back(enc_i(12'hfff, 5'd0, 3'b000, 5'd10, `OP_IMM));
        prog_q.push_back(enc_i(12'h008, 5'd0, 3'b010, 5'd11, `OP_LOAD));
        prog_q.push_back(enc_i(12'h001, 5'd10, 3'b000, 5'd12, `OP_IMM));
        prog_q.push_back(enc_r(7'h00, 5'd11, 5'd11, 3'b000, 5'd13));
        // taken BEQ to 68 over two shadow slots
        prog_q.push_back(enc_b(13'd12, 5'd0, 5'd12, 3'b000));
        prog_q.push_back(enc_i(12'h001, 5'd0, 3'b000, 5'd14, `OP_IMM));
        prog_q.push_back(enc_i(12'h002, 5'd0, 3'b000, 5'd14, `OP_IMM));
        // JAL to 84
        prog_q.push_back(enc_j(21'd16, 5'd15));
        prog_q.push_back(enc_i(12'h003, 5'd0, 3'b000, 5'd16, `OP_IMM));
        prog_q.push_back(enc_i(12'h004, 5'd0, 3'b000, 5'd16, `OP_IMM));
        prog_q.push_back(enc_i(12'h005, 5'd0, 3'b000, 5'd16, `OP_IMM));
        // BNE on equal values falls through
        prog_q.push_back(enc_b(13'd8, 5'd4, 5'd1, 3'b001));
        prog_q.push_back(enc_i(12'h007, 5'd0, 3'b000, 5'd0, `OP_IMM));
        prog_q.push_back(enc_r(7'h00, 5'd15, 5'd0, 3'b000, 5'd17));
        // two writes of x18 in flight and x17 read in its writeback cycle
        prog_q.push_back(enc_i(12'h005, 5'd0, 3'b000, 5'd18, `OP_IMM));
        prog_q.push_back(enc_i(12'h001, 5'd18, 3'b000, 5'd18, `OP_IMM));
        prog_q.push_back(enc_r(7'h00, 5'd17, 5'd18, 3'b000, 5'd19));
    endtask

    task automatic load_expected();
        exp_q.push_back({32'd0,  5'd1,  32'h0000_00f0});
        exp_q.push_back({32'd4,  5'd2,  32'h0000_00ff});
        exp_q.push_back({32'd8,  5'd3,  32'h0000_01ef});
        exp_q.push_back({32'd12, 5'd4,  32'h0000_00f0});
        exp_q.push_back({32'd16, 5'd5,  32'h0000_00e0});
        exp_q.push_back({32'd20, 5'd6,  32'h0000_00f0});
        exp_q.push_back({32'd24, 5'd7,  32'h0000_0010});
        exp_q.push_back({32'd28, 5'd8,  32'h1234_5000});
        exp_q.push_back({32'd32, 5'd9,  32'h1234_5010});
        exp_q.push_back({32'd36, 5'd0,  32'h0000_0000});
        exp_q.push_back({32'd40, 5'd10, 32'hffff_ffff});
        exp_q.push_back({32'd44, 5'd11, 32'h1234_5010});
        exp_q.push_back({32'd48, 5'd12, 32'h0000_0000});
        exp_q.push_back({32'd52, 5'd13, 32'h2468_a020});
        exp_q.push_back({32'd56, 5'd0,  32'h0000_0000});
        exp_q.push_back({32'd68, 5'd15, 32'h0000_0048});
        exp_q.push_back({32'd84, 5'd0,  32'h0000_0000});
        exp_q.push_back({32'd88, 5'd0,  32'h0000_0000});
        exp_q.push_back({32'd92, 5'd17, 32'h0000_0048});
        exp_q.push_back({32'd96, 5'd18, 32'h0000_0005});
        exp_q.push_back({32'd100, 5'd18, 32'h0000_0006});
        exp_q.push_back({32'd104, 5'd19, 32'h0000_004e});
    endtask

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        abort_run();
    endtask

    task automatic check_idle();
        assert (retire_valid == 1'b0) else
            report_mismatch("retire_valid_o", {31'd0, retire_valid}, 32'd0);
        assert (imem_addr == 32'd0) else
            report_mismatch("imem_addr_o", imem_addr, 32'd0);
    endtask

    task automatic check_retire(input logic [68:0] e);
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] data;
        pc   = e[68:37];
        rd   = e[36:32];
        data = e[31:0];
        assert (retire_pc == pc) else
            report_mismatch("retire_pc_o", retire_pc, pc);
        assert (retire_rd == rd) else
            report_mismatch("retire_rd_o", {27'd0, retire_rd}, {27'd0, rd});
        // stores, branches and x0 writes carry no register result
        if (rd != 5'd0) begin
            assert (retire_data == data) else
                report_mismatch("retire_data_o", retire_data, data);
        end
    endtask

    // instruction memory model drives the word shortly after the edge
    always @(posedge clk) begin
        #1;
        imem_data = fetch_word(imem_addr);
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= 4 * prog_q.size() + 40) begin
            $display("timeout: retirements incomplete after %0d cycles", cycle_cnt);
            abort_run();
        end
    end

    initial begin
        arst_n    = 1'b0;
        imem_data = NOP;
        load_program();
        load_expected();
        repeat (16) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        #1 arst_n = 1'b1;
        // nothing retires in the first cycle out of reset
        @(negedge clk);
        check_idle();
        ret_idx = 0;
        while (ret_idx < exp_q.size()) begin
            @(negedge clk);
            if (retire_valid) begin
                check_retire(exp_q[ret_idx]);
                ret_idx++;
            end
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== include/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath widths
`define XLEN        32
`define INST_LEN    32

// major opcodes of the supported subset
`define OP_REG      7'b0110011
`define OP_IMM      7'b0010011
`define OP_LUI      7'b0110111
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011
`define OP_JAL      7'b1101111

// data memory size in words
`define DMEM_DEPTH  64

`endif

// ==== run.sh ====
#!/usr/bin/env bash
# builds and runs the rv_core testbench with Verilator, result is taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
{ verilator --binary --timing --assert -f build.f --top-module rv_core_tb \
    -o rv_core_sim && ./obj_dir/rv_core_sim; } > sim.log 2>&1
grep -q "Checks failed" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "All checks passed" sim.log && echo "simulation passed" || \
    { echo "no result, see sim.log"; exit 1; }

// ==== source/ex_stage.sv ====
`include "rv_consts.svh"

module ex_stage import rv_pkg::*; (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  id_ex_t      id_ex_i,
    fwd_if.stage        fwd,
    wb_if.snk           wb,

    output ex_ls_t      ex_ls_o,
    redirect_if.src     redir
);

    ex_ls_t             ex_ls_q;
    logic [`XLEN-1:0]   op_a;
    logic [`XLEN-1:0]   rs2_fwd;
    logic [`XLEN-1:0]   op_b;
    logic [`XLEN-1:0]   alu_res;
    logic [`XLEN-1:0]   result;
    logic               eq;
    logic               br_taken;
    logic               taken;

    function automatic logic [`XLEN-1:0] fwd_mux(
        input fwd_sel_e         sel,
        input logic [`XLEN-1:0] reg_val,
        input logic [`XLEN-1:0] ls_val,
        input logic [`XLEN-1:0] wb_val
    );
        case (sel)
            FWD_LS:  return ls_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign fwd.rs1 = id_ex_i.ctrl.rs1;
    assign fwd.rs2 = id_ex_i.ctrl.rs2;

    assign op_a    = fwd_mux(fwd.rs1_sel, id_ex_i.rs1_val, ex_ls_q.alu_res, wb.data);
    assign rs2_fwd = fwd_mux(fwd.rs2_sel, id_ex_i.rs2_val, ex_ls_q.alu_res, wb.data);
    assign op_b    = id_ex_i.ctrl.use_imm ? id_ex_i.imm : rs2_fwd;

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = op_a + op_b;
        endcase
    end

    // branch compare on forwarded operands
    assign eq       = (op_a == rs2_fwd);
    assign br_taken = id_ex_i.ctrl.is_branch && (id_ex_i.ctrl.branch_ne ? !eq : eq);
    assign taken    = id_ex_i.valid && (br_taken || id_ex_i.ctrl.is_jal);

    assign redir.taken  = taken;
    assign redir.flush  = taken;
    assign redir.target = id_ex_i.pc + id_ex_i.imm;

    // JAL writes its link address
    assign result = id_ex_i.ctrl.is_jal ? id_ex_i.pc + `XLEN'd4 : alu_res;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_ls_q <= '0;
        end else begin
            ex_ls_q <= '{valid:      id_ex_i.valid,
                         pc:         id_ex_i.pc,
                         alu_res:    result,
                         store_data: rs2_fwd,
                         rd:         id_ex_i.ctrl.rd,
                         reg_we:     id_ex_i.ctrl.reg_we,
                         is_load:    id_ex_i.ctrl.is_load,
                         is_store:   id_ex_i.ctrl.is_store};
        end
    end

    assign ex_ls_o = ex_ls_q;

endmodule

// ==== source/forwarding.sv ====
module forwarding import rv_pkg::*; (
    fwd_if.fwd      fwd,
    input ex_ls_t   ls_i,
    wb_if.snk       wb
);

    // load data is not ready in load/store, only from writeback
    function automatic fwd_sel_e pick_src(
        input logic [4:0]   idx,
        input ex_ls_t       ls,
        input logic         wb_en,
        input logic [4:0]   wb_rd
    );
        if (idx == 5'd0) begin
            return FWD_REG;
        end else if (ls.valid && ls.reg_we && !ls.is_load && ls.rd == idx) begin
            return FWD_LS;
        end else if (wb_en && wb_rd == idx) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign fwd.rs1_sel = pick_src(fwd.rs1, ls_i, wb.valid && wb.we, wb.rd);
    assign fwd.rs2_sel = pick_src(fwd.rs2, ls_i, wb.valid && wb.we, wb.rd);

endmodule

// ==== source/id_stage.sv ====
`include "rv_consts.svh"

module id_stage import rv_pkg::*; (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic [`XLEN-1:0]        pc_i,
    input  logic [`INST_LEN-1:0]    instr_i,
    input  logic                    valid_i,
    redirect_if.dst                 redir,
    wb_if.snk                       wb,

    output id_ex_t                  id_ex_o
);

    logic [`XLEN-1:0]   regs [0:31];
    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [4:0]         rs1;
    logic [4:0]         rs2;
    logic               wb_wr;
    logic [`XLEN-1:0]   rs1_val;
    logic [`XLEN-1:0]   rs2_val;
    logic [`XLEN-1:0]   imm;
    ctrl_t              ctrl;
    id_ex_t             id_ex_q;

    function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? ALU_SUB : ALU_ADD;
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];

    always_comb begin
        ctrl     = '0;
        ctrl.rd  = instr_i[11:7];
        ctrl.rs1 = rs1;
        ctrl.rs2 = rs2;
        imm      = '0;
        case (opcode)
            `OP_REG: begin
                ctrl.reg_we = 1'b1;
                ctrl.alu_op = alu_from_f3(funct3, instr_i[30]);
            end
            `OP_IMM: begin
                ctrl.reg_we  = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.alu_op  = alu_from_f3(funct3, 1'b0);
                imm          = {{20{instr_i[31]}}, instr_i[31:20]};
            end
            `OP_LUI: begin
                ctrl.reg_we  = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.alu_op  = ALU_PASS_B;
                imm          = {instr_i[31:12], 12'b0};
            end
            `OP_LOAD: begin
                ctrl.reg_we  = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.is_load = 1'b1;
                imm          = {{20{instr_i[31]}}, instr_i[31:20]};
            end
            `OP_STORE: begin
                ctrl.use_imm  = 1'b1;
                ctrl.is_store = 1'b1;
                imm           = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            end
            `OP_BRANCH: begin
                // funct3 bit 0 tells BNE from BEQ
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = funct3[0];
                imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                       instr_i[30:25], instr_i[11:8], 1'b0};
            end
            `OP_JAL: begin
                ctrl.reg_we = 1'b1;
                ctrl.is_jal = 1'b1;
                imm = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                       instr_i[20], instr_i[30:21], 1'b0};
            end
            default: ;
        endcase
    end

    // register file, x0 never written
    assign wb_wr = wb.valid && wb.we && (wb.rd != 5'd0);

    always_ff @(posedge clk_i) begin
        if (wb_wr) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // same-cycle writeback is seen by this decode
    assign rs1_val = (rs1 == 5'd0) ? '0 :
                     (wb_wr && wb.rd == rs1) ? wb.data : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 :
                     (wb_wr && wb.rd == rs2) ? wb.data : regs[rs2];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= '{valid:   valid_i & ~redir.flush,
                         pc:      pc_i,
                         rs1_val: rs1_val,
                         rs2_val: rs2_val,
                         imm:     imm,
                         ctrl:    ctrl};
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

// ==== source/if_stage.sv ====
`include "rv_consts.svh"

module if_stage (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic [`INST_LEN-1:0]    imem_data_i,
    redirect_if.dst                 redir,

    output logic [`XLEN-1:0]        imem_addr_o,
    output logic [`XLEN-1:0]        pc_o,
    output logic [`INST_LEN-1:0]    instr_o,
    output logic                    valid_o
);

    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] pc_next;

    assign imem_addr_o = pc_q;

    // redirect wins over the sequential step
    assign pc_next = redir.taken ? redir.target : pc_q + `XLEN'd4;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_next;
        end
    end

    // IF/ID register, the fetched word is dropped on a flush
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_o    <= '0;
            instr_o <= '0;
            valid_o <= 1'b0;
        end else begin
            pc_o    <= pc_q;
            instr_o <= imem_data_i;
            valid_o <= ~redir.flush;
        end
    end

endmodule

// ==== source/ls_stage.sv ====
`include "rv_consts.svh"

module ls_stage import rv_pkg::*; (
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  ex_ls_t  ex_ls_i,

    wb_if.src       wb
);

    localparam int ADDR_W = $clog2(`DMEM_DEPTH);

    logic [`XLEN-1:0]   dmem [0:`DMEM_DEPTH-1];
    logic [ADDR_W-1:0]  word_addr;
    logic [`XLEN-1:0]   load_data;
    ls_wb_t             ls_wb_q;

    // word addressed, low two bits ignored
    assign word_addr = ex_ls_i.alu_res[ADDR_W+1:2];
    assign load_data = dmem[word_addr];

    always_ff @(posedge clk_i) begin
        if (ex_ls_i.valid && ex_ls_i.is_store) begin
            dmem[word_addr] <= ex_ls_i.store_data;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ls_wb_q <= '0;
        end else begin
            ls_wb_q <= '{valid:   ex_ls_i.valid,
                         pc:      ex_ls_i.pc,
                         rd:      ex_ls_i.rd,
                         reg_we:  ex_ls_i.reg_we,
                         wb_data: ex_ls_i.is_load ? load_data : ex_ls_i.alu_res};
        end
    end

    assign wb.valid = ls_wb_q.valid;
    assign wb.we    = ls_wb_q.reg_we;
    assign wb.rd    = ls_wb_q.rd;
    assign wb.data  = ls_wb_q.wb_data;
    assign wb.pc    = ls_wb_q.pc;

endmodule

// ==== source/rv_core.sv ====
`include "rv_consts.svh"

module rv_core import rv_pkg::*; (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic [`INST_LEN-1:0]    imem_data_i,

    output logic [`XLEN-1:0]        imem_addr_o,
    output logic                    retire_valid_o,
    output logic [`XLEN-1:0]        retire_pc_o,
    output logic [4:0]              retire_rd_o,
    output logic [`XLEN-1:0]        retire_data_o
);

    logic [`XLEN-1:0]       pc_id;
    logic [`INST_LEN-1:0]   instr_id;
    logic                   valid_id;
    id_ex_t                 id_ex;
    ex_ls_t                 ex_ls;

    redirect_if redir ();
    wb_if       wb ();
    fwd_if      fwd ();

    if_stage if_stage_u (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .imem_data_i    (imem_data_i),
        .redir          (redir.dst),
        .imem_addr_o    (imem_addr_o),
        .pc_o           (pc_id),
        .instr_o        (instr_id),
        .valid_o        (valid_id)
    );

    id_stage id_stage_u (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .pc_i           (pc_id),
        .instr_i        (instr_id),
        .valid_i        (valid_id),
        .redir          (redir.dst),
        .wb             (wb.snk),
        .id_ex_o        (id_ex)
    );

    forwarding forwarding_u (
        .fwd            (fwd.fwd),
        .ls_i           (ex_ls),
        .wb             (wb.snk)
    );

    ex_stage ex_stage_u (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .id_ex_i        (id_ex),
        .fwd            (fwd.stage),
        .wb             (wb.snk),
        .ex_ls_o        (ex_ls),
        .redir          (redir.src)
    );

    ls_stage ls_stage_u (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .ex_ls_i        (ex_ls),
        .wb             (wb.src)
    );

    // retire port mirrors the writeback bus
    assign retire_valid_o = wb.valid;
    assign retire_pc_o    = wb.pc;
    assign retire_rd_o    = wb.we ? wb.rd : 5'd0;
    assign retire_data_o  = wb.data;

endmodule

// ==== source/rv_ifs.sv ====
`include "rv_consts.svh"

// branch / jump redirect from execute
interface redirect_if;
    logic               taken;
    logic [`XLEN-1:0]   target;
    logic               flush;

    modport src (output taken, target, flush);
    modport dst (input taken, target, flush);
endinterface

// writeback bus, also the retire port
interface wb_if;
    logic               valid;
    logic               we;
    logic [4:0]         rd;
    logic [`XLEN-1:0]   data;
    logic [`XLEN-1:0]   pc;

    modport src (output valid, we, rd, data, pc);
    modport snk (input valid, we, rd, data, pc);
endinterface

// source indices out, operand selects back
interface fwd_if import rv_pkg::*; ();
    logic [4:0] rs1;
    logic [4:0] rs2;
    fwd_sel_e   rs1_sel;
    fwd_sel_e   rs2_sel;

    modport stage (output rs1, rs2, input rs1_sel, rs2_sel);
    modport fwd (input rs1, rs2, output rs1_sel, rs2_sel);
endinterface

// ==== source/rv_pkg.sv ====
`include "rv_consts.svh"

package rv_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    // operand source chosen by the forwarding unit
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_LS,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e    alu_op;
        logic       use_imm;
        logic       is_load;
        logic       is_store;
        logic       is_branch;
        logic       branch_ne;
        logic       is_jal;
        logic       reg_we;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
    } ctrl_t;

    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   rs1_val;
        logic [`XLEN-1:0]   rs2_val;
        logic [`XLEN-1:0]   imm;
        ctrl_t              ctrl;
    } id_ex_t;

    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   alu_res;
        logic [`XLEN-1:0]   store_data;
        logic [4:0]         rd;
        logic               reg_we;
        logic               is_load;
        logic               is_store;
    } ex_ls_t;

    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   pc;
        logic [4:0]         rd;
        logic               reg_we;
        logic [`XLEN-1:0]   wb_data;
    } ls_wb_t;

endpackage
